//--- common/slam_pkg.sv
package slam_pkg;

  // datapath and bus widths
  localparam int DATA_W   = 32;
  localparam int ADDR_W   = 32;
  // landmark index width, matches the default ROW_LEN
  localparam int LM_IDX_W = 10;

  typedef logic signed [DATA_W-1:0] data_t;
  typedef logic [ADDR_W-1:0]        plb_addr_t;
  typedef logic [LM_IDX_W-1:0]      lm_idx_t;

  // stage codes as driven by the processor
  // code 4 (data association) is not handled here
  typedef enum logic [2:0] {
    STAGE_IDLE = 3'd0,
    STAGE_PRD  = 3'd1,
    STAGE_NEW  = 3'd2,
    STAGE_UPD  = 3'd3
  } stage_e;

  // robot pose
  typedef struct packed {
    data_t x;
    data_t y;
    data_t theta;
  } robot_state_t;

  // one landmark, two words
  typedef struct packed {
    data_t lx;
    data_t ly;
  } landmark_t;

  // innovation pair of the update stage
  typedef struct packed {
    data_t vt_1;
    data_t vt_2;
  } innov_t;

  // six raw results from the nonlinear unit
  typedef struct packed {
    data_t result_0;
    data_t result_1;
    data_t result_2;
    data_t result_3;
    data_t result_4;
    data_t result_5;
  } nl_result_t;

  // commands from sequencer to PLB engine
  typedef enum logic [2:0] {
    PLB_NONE,
    PLB_RD_ROBOT,
    PLB_RD_ROBOT_LM,
    PLB_WR_ROBOT,
    PLB_WR_LM,
    PLB_WR_INNOV
  } plb_op_e;

  // PLB word map, in words
  localparam plb_addr_t ROBOT_BASE     = 32'd0;
  localparam plb_addr_t LM_BASE        = 32'd3;
  localparam plb_addr_t INNOV_BASE     = 32'd4096;
  localparam plb_addr_t BYTES_PER_WORD = 32'd4;

  // words per region entry
  localparam int ROBOT_WORDS = 3;
  localparam int LM_WORDS    = 2;
  localparam int INNOV_WORDS = 2;

endpackage

//--- logic/stage_sequencer.sv
module stage_sequencer #(
  parameter int ROW_LEN = 10
) (
  input  logic                clk,
  input  logic                sys_rst,
  input  slam_pkg::stage_e    i_stage_val,
  input  slam_pkg::lm_idx_t   i_l_k,
  input  logic                i_op_done,
  input  logic                i_result_valid,
  output logic                o_stage_rdy,
  output slam_pkg::plb_op_e   o_plb_op,
  output slam_pkg::lm_idx_t   o_lm_idx,
  output logic                o_init_predict,
  output logic                o_init_newlm,
  output logic                o_init_update
);

  import slam_pkg::*;

  // phases of one stage
  typedef enum logic [2:0] {
    S_IDLE,
    S_FETCH,
    S_LAUNCH,
    S_WAIT,
    S_WRITE
  } seq_state_e;

  seq_state_e         state;
  seq_state_e         state_nxt;
  stage_e             stage_q;
  logic [ROW_LEN-1:0] l_k_q;
  logic               stage_ok;
  logic               accept;

  // only predict, new landmark and update start a stage
  assign stage_ok = (i_stage_val == STAGE_PRD) ||
                    (i_stage_val == STAGE_NEW) ||
                    (i_stage_val == STAGE_UPD);
  assign accept   = (state == S_IDLE) && stage_ok;

  // ready is a level, low for the whole stage
  assign o_stage_rdy = (state == S_IDLE);

  // index held for the engine's address math
  assign o_lm_idx = lm_idx_t'(l_k_q);

  // one-cycle init in the launch phase, by stage kind
  assign o_init_predict = (state == S_LAUNCH) && (stage_q == STAGE_PRD);
  assign o_init_newlm   = (state == S_LAUNCH) && (stage_q == STAGE_NEW);
  assign o_init_update  = (state == S_LAUNCH) && (stage_q == STAGE_UPD);

  always_comb begin
    state_nxt = state;
    case (state)
      S_IDLE: begin
        if (accept) begin
          state_nxt = S_FETCH;
        end
      end
      // wait for last read word to land
      S_FETCH: begin
        if (i_op_done) begin
          state_nxt = S_LAUNCH;
        end
      end
      S_LAUNCH: begin
        state_nxt = S_WAIT;
      end
      // nonlinear latency is open ended
      S_WAIT: begin
        if (i_result_valid) begin
          state_nxt = S_WRITE;
        end
      end
      S_WRITE: begin
        if (i_op_done) begin
          state_nxt = S_IDLE;
        end
      end
      default: begin
        state_nxt = S_IDLE;
      end
    endcase
  end

  // engine command, a pulse on the phase entry edge
  always_comb begin
    o_plb_op = PLB_NONE;
    if (accept) begin
      // predict needs only the pose
      if (i_stage_val == STAGE_PRD) begin
        o_plb_op = PLB_RD_ROBOT;
      end else begin
        o_plb_op = PLB_RD_ROBOT_LM;
      end
    end else if ((state == S_WAIT) && i_result_valid) begin
      case (stage_q)
        STAGE_PRD: o_plb_op = PLB_WR_ROBOT;
        STAGE_NEW: o_plb_op = PLB_WR_LM;
        default:   o_plb_op = PLB_WR_INNOV;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (sys_rst) begin
      state   <= S_IDLE;
      stage_q <= STAGE_IDLE;
      l_k_q   <= '0;
    end else begin
      state <= state_nxt;
      // stage code and index sampled on acceptance
      if (accept) begin
        stage_q <= i_stage_val;
        l_k_q   <= i_l_k[ROW_LEN-1:0];
      end
    end
  end

endmodule

//--- plb/plb_engine.sv
module plb_engine #(
  parameter int ROW_LEN = 10
) (
  input  logic                   clk,
  input  logic                   sys_rst,
  input  slam_pkg::plb_op_e      i_plb_op,
  input  slam_pkg::lm_idx_t      i_lm_idx,
  input  slam_pkg::robot_state_t i_robot_upd,
  input  slam_pkg::landmark_t    i_lm_upd,
  input  slam_pkg::innov_t       i_innov,
  input  slam_pkg::data_t        i_plb_dout,
  output logic                   o_plb_en,
  output logic                   o_plb_we,
  output slam_pkg::plb_addr_t    o_plb_addr,
  output slam_pkg::data_t        o_plb_din,
  output logic                   o_op_done,
  output slam_pkg::robot_state_t o_robot,
  output slam_pkg::landmark_t    o_lm
);

  import slam_pkg::*;

  plb_op_e      op_q;
  logic         busy;
  logic [2:0]   word_cnt;
  logic [2:0]   last_idx;
  logic         is_wr;
  logic         last_word;
  plb_addr_t    lm_word;
  plb_addr_t    word_idx;
  // read return pipeline, one cycle behind the port
  logic         rd_vld_q;
  logic [2:0]   rd_idx_q;
  logic         rd_last_q;
  robot_state_t robot_q;
  landmark_t    lm_q;

  // word count of each command, minus one
  always_comb begin
    case (op_q)
      PLB_RD_ROBOT:    last_idx = 3'(ROBOT_WORDS - 1);
      PLB_RD_ROBOT_LM: last_idx = 3'(ROBOT_WORDS + LM_WORDS - 1);
      PLB_WR_ROBOT:    last_idx = 3'(ROBOT_WORDS - 1);
      PLB_WR_LM:       last_idx = 3'(LM_WORDS - 1);
      PLB_WR_INNOV:    last_idx = 3'(INNOV_WORDS - 1);
      default:         last_idx = 3'd0;
    endcase
  end

  assign is_wr     = (op_q == PLB_WR_ROBOT) || (op_q == PLB_WR_LM) ||
                     (op_q == PLB_WR_INNOV);
  assign last_word = busy && (word_cnt == last_idx);

  // first word of landmark k, region scales with ROW_LEN
  assign lm_word = LM_BASE + plb_addr_t'(LM_WORDS) * plb_addr_t'(i_lm_idx[ROW_LEN-1:0]);

  // word index for the current count
  always_comb begin
    case (op_q)
      PLB_RD_ROBOT, PLB_WR_ROBOT: begin
        word_idx = ROBOT_BASE + plb_addr_t'(word_cnt);
      end
      // pose words first, then the landmark pair
      PLB_RD_ROBOT_LM: begin
        if (word_cnt < 3'(ROBOT_WORDS)) begin
          word_idx = ROBOT_BASE + plb_addr_t'(word_cnt);
        end else begin
          word_idx = lm_word + plb_addr_t'(word_cnt - 3'(ROBOT_WORDS));
        end
      end
      PLB_WR_LM:    word_idx = lm_word + plb_addr_t'(word_cnt);
      PLB_WR_INNOV: word_idx = INNOV_BASE + plb_addr_t'(word_cnt);
      default:      word_idx = ROBOT_BASE;
    endcase
  end

  // write data from the capture block's registers
  always_comb begin
    o_plb_din = '0;
    case (op_q)
      PLB_WR_ROBOT: begin
        case (word_cnt)
          3'd0:    o_plb_din = i_robot_upd.x;
          3'd1:    o_plb_din = i_robot_upd.y;
          default: o_plb_din = i_robot_upd.theta;
        endcase
      end
      PLB_WR_LM: begin
        o_plb_din = (word_cnt == 3'd0) ? i_lm_upd.lx : i_lm_upd.ly;
      end
      PLB_WR_INNOV: begin
        o_plb_din = (word_cnt == 3'd0) ? i_innov.vt_1 : i_innov.vt_2;
      end
      default: begin
        o_plb_din = '0;
      end
    endcase
  end

  // port driven straight from the counter state
  assign o_plb_en   = busy;
  assign o_plb_we   = busy && is_wr;
  assign o_plb_addr = word_idx * BYTES_PER_WORD;

  // writes finish on their last word, reads when last data lands
  assign o_op_done = (last_word && is_wr) || rd_last_q;

  always_ff @(posedge clk) begin
    if (sys_rst) begin
      busy      <= 1'b0;
      op_q      <= PLB_NONE;
      word_cnt  <= '0;
      rd_vld_q  <= 1'b0;
      rd_idx_q  <= '0;
      rd_last_q <= 1'b0;
    end else begin
      rd_vld_q  <= busy && !is_wr;
      rd_idx_q  <= word_cnt;
      rd_last_q <= last_word && !is_wr;
      if (!busy) begin
        // new command, first word next cycle
        if (i_plb_op != PLB_NONE) begin
          busy     <= 1'b1;
          op_q     <= i_plb_op;
          word_cnt <= '0;
        end
      end else if (last_word) begin
        busy     <= 1'b0;
        op_q     <= PLB_NONE;
        word_cnt <= '0;
      end else begin
        word_cnt <= word_cnt + 3'd1;
      end
    end
  end

  // returning words steered by the delayed count
  always_ff @(posedge clk) begin
    if (rd_vld_q) begin
      case (rd_idx_q)
        3'd0:    robot_q.x     <= i_plb_dout;
        3'd1:    robot_q.y     <= i_plb_dout;
        3'd2:    robot_q.theta <= i_plb_dout;
        3'd3:    lm_q.lx       <= i_plb_dout;
        default: lm_q.ly       <= i_plb_dout;
      endcase
    end
  end

  assign o_robot = robot_q;
  assign o_lm    = lm_q;

endmodule

//--- logic/nl_result_capture.sv
module nl_result_capture (
  input  logic                   clk,
  input  logic                   sys_rst,
  input  logic                   i_done_predict,
  input  logic                   i_done_newlm,
  input  logic                   i_done_update,
  input  slam_pkg::nl_result_t   i_result,
  input  slam_pkg::robot_state_t i_robot,
  input  slam_pkg::landmark_t    i_lm,
  input  slam_pkg::data_t        i_rk,
  input  slam_pkg::data_t        i_phi,
  output slam_pkg::robot_state_t o_robot_upd,
  output slam_pkg::landmark_t    o_lm_upd,
  output slam_pkg::innov_t       o_innov,
  output logic                   o_result_valid
);

  // predicted pose
  // result_2/result_3 are the x/y steps, result_1 the heading step
  always_ff @(posedge clk) begin
    if (sys_rst) begin
      o_robot_upd <= '0;
    end else if (i_done_predict) begin
      o_robot_upd.x     <= i_robot.x + i_result.result_2;
      o_robot_upd.y     <= i_robot.y + i_result.result_3;
      o_robot_upd.theta <= i_robot.theta + i_result.result_1;
    end
  end

  // new landmark position
  // x and y offsets come crossed in result_3/result_2
  always_ff @(posedge clk) begin
    if (sys_rst) begin
      o_lm_upd <= '0;
    end else if (i_done_newlm) begin
      o_lm_upd.lx <= i_lm.lx + i_result.result_3;
      o_lm_upd.ly <= i_lm.ly + i_result.result_2;
    end
  end

  // innovation, measured minus predicted range and bearing
  always_ff @(posedge clk) begin
    if (sys_rst) begin
      o_innov <= '0;
    end else if (i_done_update) begin
      o_innov.vt_1 <= i_rk - i_result.result_0;
      o_innov.vt_2 <= i_phi - i_result.result_1;
    end
  end

  // any done, one cycle late, lines up with the registered values
  always_ff @(posedge clk) begin
    if (sys_rst) begin
      o_result_valid <= 1'b0;
    end else begin
      o_result_valid <= i_done_predict || i_done_newlm || i_done_update;
    end
  end

endmodule

//--- logic/slam_top.sv
module slam_top #(
  parameter int ROW_LEN = 10
) (
  input  logic                 clk,
  input  logic                 sys_rst,

  // stage command from the processor
  input  slam_pkg::stage_e     i_stage_val,
  output logic                 o_stage_rdy,
  input  slam_pkg::lm_idx_t    i_l_k,
  input  slam_pkg::data_t      i_rk,
  input  slam_pkg::data_t      i_phi,

  // shared block RAM port
  output logic                 o_plb_en,
  output logic                 o_plb_we,
  output slam_pkg::plb_addr_t  o_plb_addr,
  output slam_pkg::data_t      o_plb_din,
  input  slam_pkg::data_t      i_plb_dout,

  // nonlinear unit, start pulses and operands
  output logic                 o_init_predict,
  output logic                 o_init_newlm,
  output logic                 o_init_update,
  output slam_pkg::data_t      o_xk,
  output slam_pkg::data_t      o_yk,
  output slam_pkg::data_t      o_xita,
  output slam_pkg::data_t      o_lkx,
  output slam_pkg::data_t      o_lky,

  // nonlinear unit, done pulses and results
  input  logic                 i_done_predict,
  input  logic                 i_done_newlm,
  input  logic                 i_done_update,
  input  slam_pkg::data_t      i_result_0,
  input  slam_pkg::data_t      i_result_1,
  input  slam_pkg::data_t      i_result_2,
  input  slam_pkg::data_t      i_result_3,
  input  slam_pkg::data_t      i_result_4,
  input  slam_pkg::data_t      i_result_5
);

  import slam_pkg::*;

  plb_op_e      plb_op;
  lm_idx_t      lm_idx;
  logic         op_done;
  logic         result_valid;
  robot_state_t robot;
  landmark_t    lm;
  robot_state_t robot_upd;
  landmark_t    lm_upd;
  innov_t       innov;
  nl_result_t   nl_result;

  // bundle the six result buses
  assign nl_result = '{
    result_0: i_result_0,
    result_1: i_result_1,
    result_2: i_result_2,
    result_3: i_result_3,
    result_4: i_result_4,
    result_5: i_result_5
  };

  // fetched state straight to the nonlinear unit
  assign o_xk   = robot.x;
  assign o_yk   = robot.y;
  assign o_xita = robot.theta;
  assign o_lkx  = lm.lx;
  assign o_lky  = lm.ly;

  stage_sequencer #(
    .ROW_LEN (ROW_LEN)
  ) u_stage_sequencer (
    .clk            (clk),
    .sys_rst        (sys_rst),
    .i_stage_val    (i_stage_val),
    .i_l_k          (i_l_k),
    .i_op_done      (op_done),
    .i_result_valid (result_valid),
    .o_stage_rdy    (o_stage_rdy),
    .o_plb_op       (plb_op),
    .o_lm_idx       (lm_idx),
    .o_init_predict (o_init_predict),
    .o_init_newlm   (o_init_newlm),
    .o_init_update  (o_init_update)
  );

  plb_engine #(
    .ROW_LEN (ROW_LEN)
  ) u_plb_engine (
    .clk         (clk),
    .sys_rst     (sys_rst),
    .i_plb_op    (plb_op),
    .i_lm_idx    (lm_idx),
    .i_robot_upd (robot_upd),
    .i_lm_upd    (lm_upd),
    .i_innov     (innov),
    .i_plb_dout  (i_plb_dout),
    .o_plb_en    (o_plb_en),
    .o_plb_we    (o_plb_we),
    .o_plb_addr  (o_plb_addr),
    .o_plb_din   (o_plb_din),
    .o_op_done   (op_done),
    .o_robot     (robot),
    .o_lm        (lm)
  );

  nl_result_capture u_nl_result_capture (
    .clk            (clk),
    .sys_rst        (sys_rst),
    .i_done_predict (i_done_predict),
    .i_done_newlm   (i_done_newlm),
    .i_done_update  (i_done_update),
    .i_result       (nl_result),
    .i_robot        (robot),
    .i_lm           (lm),
    .i_rk           (i_rk),
    .i_phi          (i_phi),
    .o_robot_upd    (robot_upd),
    .o_lm_upd       (lm_upd),
    .o_innov        (innov),
    .o_result_valid (result_valid)
  );

endmodule

//--- tests/tb_slam_top.sv
module tb_slam_top;

  import slam_pkg::*;

  localparam int ROW_LEN    = 10;
  localparam int MEM_DEPTH  = 8192;
  localparam int TD_DEPTH   = 256;
  localparam int MAX_STAGES = 32;
  localparam int REC_WORDS  = 10;

  logic    clk;
  logic    sys_rst;
  stage_e  i_stage_val;
  lm_idx_t i_l_k;
  data_t   i_rk;
  data_t   i_phi;
  data_t   i_plb_dout;
  logic    i_done_predict;
  logic    i_done_newlm;
  logic    i_done_update;
  data_t   i_result_0;
  data_t   i_result_1;
  data_t   i_result_2;
  data_t   i_result_3;
  data_t   i_result_4;
  data_t   i_result_5;
  logic      o_stage_rdy;
  logic      o_plb_en;
  logic      o_plb_we;
  plb_addr_t o_plb_addr;
  data_t     o_plb_din;
  logic      o_init_predict;
  logic      o_init_newlm;
  logic      o_init_update;
  data_t     o_xk;
  data_t     o_yk;
  data_t     o_xita;
  data_t     o_lkx;
  data_t     o_lky;

  // PLB contents, DUT side and reference model side
  data_t       mem [0:MEM_DEPTH-1];
  data_t       model_mem [0:MEM_DEPTH-1];
  logic [31:0] tdata [0:TD_DEPTH-1];
  data_t       stage_rec [0:MAX_STAGES-1][0:REC_WORDS-1];
  data_t       cur_res [0:5];
  int          cur_lk;
  int          n_stage;
  int          errors;
  int          init_count;
  int          write_count;
  int          limit_cycles;
  logic        loaded;
  integer      seed;

  slam_top #(
    .ROW_LEN (ROW_LEN)
  ) dut (
    .clk            (clk),
    .sys_rst        (sys_rst),
    .i_stage_val    (i_stage_val),
    .o_stage_rdy    (o_stage_rdy),
    .i_l_k          (i_l_k),
    .i_rk           (i_rk),
    .i_phi          (i_phi),
    .o_plb_en       (o_plb_en),
    .o_plb_we       (o_plb_we),
    .o_plb_addr     (o_plb_addr),
    .o_plb_din      (o_plb_din),
    .i_plb_dout     (i_plb_dout),
    .o_init_predict (o_init_predict),
    .o_init_newlm   (o_init_newlm),
    .o_init_update  (o_init_update),
    .o_xk           (o_xk),
    .o_yk           (o_yk),
    .o_xita         (o_xita),
    .o_lkx          (o_lkx),
    .o_lky          (o_lky),
    .i_done_predict (i_done_predict),
    .i_done_newlm   (i_done_newlm),
    .i_done_update  (i_done_update),
    .i_result_0     (i_result_0),
    .i_result_1     (i_result_1),
    .i_result_2     (i_result_2),
    .i_result_3     (i_result_3),
    .i_result_4     (i_result_4),
    .i_result_5     (i_result_5)
  );

  always #4 clk = ~clk;

  task automatic compare_value(input string name, input data_t got, input data_t exp);
    assert (got === exp) else begin
      $display("Error: %s = %h, expected %h", name, got, exp);
      errors++;
    end
  endtask

  // pose, landmark pair of index lk, innovation pair
  task automatic compare_words(input int lk);
    int lm_a;
    lm_a = int'(LM_BASE) + 2 * lk;
    for (int a = 0; a < 3; a++) begin
      compare_value($sformatf("mem[%0d]", a), mem[a], model_mem[a]);
    end
    compare_value($sformatf("mem[%0d]", lm_a), mem[lm_a], model_mem[lm_a]);
    compare_value($sformatf("mem[%0d]", lm_a + 1), mem[lm_a + 1], model_mem[lm_a + 1]);
    compare_value("mem[innov]", mem[INNOV_BASE], model_mem[INNOV_BASE]);
    compare_value("mem[innov+1]", mem[INNOV_BASE + 1], model_mem[INNOV_BASE + 1]);
  endtask

  task automatic wait_ready();
    @(negedge clk);
    while (o_stage_rdy !== 1'b1) @(negedge clk);
  endtask

  task automatic run_stage(input int code, input int lk, input data_t rk, input data_t phi);
    wait_ready();
    @(posedge clk);
    i_stage_val <= stage_e'(code);
    i_l_k       <= lm_idx_t'(lk);
    i_rk        <= rk;
    i_phi       <= phi;
    // acceptance edge, then a different valid code while busy
    @(posedge clk);
    i_stage_val <= (code == 3) ? STAGE_PRD : STAGE_UPD;
    @(negedge clk);
    assert (o_stage_rdy === 1'b0) else begin
      $display("o_stage_rdy did not fall after the stage was accepted");
      errors++;
    end
    @(posedge clk);
    i_stage_val <= STAGE_IDLE;
    wait_ready();
  endtask

  // unsupported code must leave the DUT idle
  task automatic run_ignored(input int code);
    wait_ready();
    @(posedge clk);
    i_stage_val <= stage_e'(code);
    repeat (6) begin
      @(negedge clk);
      assert (o_stage_rdy === 1'b1 && o_plb_en === 1'b0) else begin
        $display("stage code %0d was not ignored", code);
        errors++;
      end
    end
    @(posedge clk);
    i_stage_val <= STAGE_IDLE;
  endtask

  // PLB model, one cycle read latency
  always @(posedge clk) begin
    plb_addr_t widx;
    if (o_plb_en === 1'b1) begin
      widx = o_plb_addr / BYTES_PER_WORD;
      assert (widx < MEM_DEPTH) else begin
        $display("PLB access outside the memory model at byte address %h", o_plb_addr);
        errors++;
      end
      if (widx < MEM_DEPTH) begin
        if (o_plb_we) begin
          mem[widx] <= o_plb_din;
          write_count++;
        end else begin
          i_plb_dout <= mem[widx];
        end
      end
    end
  end

  always @(negedge clk) begin
    if (o_init_predict || o_init_newlm || o_init_update) begin
      init_count++;
    end
  end

  // nonlinear unit, operands checked at init, answers after a random delay
  always begin
    int   delay;
    int   lm_a;
    logic kind_prd;
    logic kind_new;
    logic kind_upd;
    @(negedge clk);
    if (o_init_predict || o_init_newlm || o_init_update) begin
      kind_prd = o_init_predict;
      kind_new = o_init_newlm;
      kind_upd = o_init_update;
      compare_value("o_xk", o_xk, model_mem[0]);
      compare_value("o_yk", o_yk, model_mem[1]);
      compare_value("o_xita", o_xita, model_mem[2]);
      if (!kind_prd) begin
        lm_a = int'(LM_BASE) + 2 * cur_lk;
        compare_value("o_lkx", o_lkx, model_mem[lm_a]);
        compare_value("o_lky", o_lky, model_mem[lm_a + 1]);
      end
      delay = 1 + ($unsigned($random(seed)) % 8);
      repeat (delay) @(posedge clk);
      i_done_predict <= kind_prd;
      i_done_newlm   <= kind_new;
      i_done_update  <= kind_upd;
      i_result_0     <= cur_res[0];
      i_result_1     <= cur_res[1];
      i_result_2     <= cur_res[2];
      i_result_3     <= cur_res[3];
      i_result_4     <= cur_res[4];
      i_result_5     <= cur_res[5];
      @(posedge clk);
      i_done_predict <= 1'b0;
      i_done_newlm   <= 1'b0;
      i_done_update  <= 1'b0;
    end
  end

  // watchdog sized from the stage count
  initial begin
    wait (loaded === 1'b1);
    repeat (limit_cycles) @(posedge clk);
    $display("timeout: run did not finish within %0d cycles", limit_cycles);
    $display("TESTBENCH FAILED");
    $finish;
  end

  initial begin
    int n_init;
    int p;
    int code;
    int lk;
    int err_before;
    int init_before;
    int wr_before;
    int exp_wr;
    int exp_init;
    int lm_a;
    int failed;
    clk = 1'b0;
    sys_rst = 1'b1;
    i_stage_val = STAGE_IDLE;
    i_l_k = '0;
    i_rk = '0;
    i_phi = '0;
    i_plb_dout = '0;
    i_done_predict = 1'b0;
    i_done_newlm = 1'b0;
    i_done_update = 1'b0;
    i_result_0 = '0;
    i_result_1 = '0;
    i_result_2 = '0;
    i_result_3 = '0;
    i_result_4 = '0;
    i_result_5 = '0;
    seed = 6;
    errors = 0;
    failed = 0;
    init_count = 0;
    write_count = 0;
    cur_lk = 0;
    loaded = 1'b0;
    for (int i = 0; i < MEM_DEPTH; i++) begin
      mem[i] = data_t'(i * 32'h9e3779b1) ^ 32'h5a5a0000;
      model_mem[i] = mem[i];
    end
    $readmemh("tests/slam_testdata.txt", tdata);
    n_init = int'(tdata[0]);
    for (int i = 0; i < n_init; i++) begin
      mem[tdata[1 + 2 * i]] = tdata[2 + 2 * i];
      model_mem[tdata[1 + 2 * i]] = tdata[2 + 2 * i];
    end
    p = 1 + 2 * n_init;
    n_stage = int'(tdata[p]);
    for (int s = 0; s < n_stage; s++) begin
      for (int w = 0; w < REC_WORDS; w++) begin
        stage_rec[s][w] = tdata[p + 1 + s * REC_WORDS + w];
      end
    end
    limit_cycles = n_stage * 40 + 100;
    loaded = 1'b1;

    repeat (3) @(posedge clk);
    sys_rst <= 1'b0;
    @(negedge clk);
    err_before = errors;
    assert (o_stage_rdy === 1'b1 && o_plb_en === 1'b0 && o_init_predict === 1'b0 &&
            o_init_newlm === 1'b0 && o_init_update === 1'b0) else begin
      $display("outputs not in their idle values after reset");
      errors++;
    end
    $display("test 0 reset: %s", (errors == err_before) ? "ok" : "failed");
    failed += (errors != err_before);

    for (int s = 0; s < n_stage; s++) begin
      code = int'(stage_rec[s][0]);
      lk = int'(stage_rec[s][1]);
      err_before = errors;
      init_before = init_count;
      wr_before = write_count;
      for (int r = 0; r < 6; r++) begin
        cur_res[r] = stage_rec[s][4 + r];
      end
      cur_lk = lk;
      lm_a = int'(LM_BASE) + 2 * lk;
      exp_init = 1;
      exp_wr = 2;
      case (code)
        1: begin
          run_stage(code, lk, stage_rec[s][2], stage_rec[s][3]);
          exp_wr = 3;
          model_mem[0] = model_mem[0] + stage_rec[s][6];
          model_mem[1] = model_mem[1] + stage_rec[s][7];
          model_mem[2] = model_mem[2] + stage_rec[s][5];
        end
        2: begin
          run_stage(code, lk, stage_rec[s][2], stage_rec[s][3]);
          model_mem[lm_a] = model_mem[lm_a] + stage_rec[s][7];
          model_mem[lm_a + 1] = model_mem[lm_a + 1] + stage_rec[s][6];
        end
        3: begin
          run_stage(code, lk, stage_rec[s][2], stage_rec[s][3]);
          model_mem[INNOV_BASE] = stage_rec[s][2] - stage_rec[s][4];
          model_mem[INNOV_BASE + 1] = stage_rec[s][3] - stage_rec[s][5];
        end
        default: begin
          run_ignored(code);
          exp_init = 0;
          exp_wr = 0;
        end
      endcase
      assert (init_count - init_before == exp_init) else begin
        $display("expected %0d init pulses, saw %0d", exp_init, init_count - init_before);
        errors++;
      end
      assert (write_count - wr_before == exp_wr) else begin
        $display("expected %0d PLB writes, saw %0d", exp_wr, write_count - wr_before);
        errors++;
      end
      compare_words(lk);
      $display("test %0d stage code %0d l_k %0d: %s", s + 1, code, lk,
               (errors == err_before) ? "ok" : "failed");
      failed += (errors != err_before);
    end

    // whole memory against the model after the full list
    err_before = errors;
    for (int i = 0; i < MEM_DEPTH; i++) begin
      compare_value($sformatf("mem[%0d]", i), mem[i], model_mem[i]);
    end
    $display("test %0d full memory compare: %s", n_stage + 1,
             (errors == err_before) ? "ok" : "failed");
    failed += (errors != err_before);

    $display("tests run %0d, tests failed %0d, errors %0d", n_stage + 2, failed, errors);
    if (errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

//--- tests/slam_testdata.txt
// init block: word count, then one line per word: word address, value
// stage block: stage count, then per stage: code l_k rk phi result_0 .. result_5
0000000a
00000000 00001000
00000001 fffff800
00000002 00000064
00000003 00000200
00000004 00000300
00000005 7ffffff0
00000006 80000010
00000015 00000123
00000016 fffffedd
00001000 deadbeef
0000000b
00000001 00000000 00000000 00000000 00000000 00000005 00000010 fffffff0 11111111 22222222
00000002 00000001 00000000 00000000 00000000 00000000 ffffffe0 00000020 00000000 00000000
00000003 00000001 00000100 fffffffe 00000080 7fffffff 00000000 00000000 00000000 00000000
00000004 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000
00000001 00000000 00000000 00000000 00000000 7fffffff 80000000 00000001 00000000 00000000
00000002 00000009 00000000 00000000 00000000 00000000 00000007 fffffff9 00000000 00000000
00000003 00000009 7fffffff 80000000 ffffffff 00000001 00000000 00000000 00000000 00000000
00000002 00000003 00000000 00000000 00000000 00000000 12345678 87654321 00000000 00000000
00000003 00000000 00000010 00000020 00000030 00000040 00000000 00000000 00000000 00000000
00000004 00000005 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000
00000001 00000000 00000000 00000000 00000000 ffffffff 00000001 ffffffff 00000000 00000000

//--- compile.f
common/slam_pkg.sv
logic/stage_sequencer.sv
plb/plb_engine.sv
logic/nl_result_capture.sv
logic/slam_top.sv
tests/tb_slam_top.sv
